//--- include/tcb_mon_settings.svh
`ifndef TCB_MON_SETTINGS_SVH
`define TCB_MON_SETTINGS_SVH

// bus widths
`define TCB_ABW 16
`define TCB_DBW 32
// one enable bit per data byte
`define TCB_BEW (`TCB_DBW/8)

// response delay in cycles after the transfer cycle
`define TCB_DLY 2

// delay buffer depth
// must cover TCB_DLY records in flight
`define TCB_MON_DEPTH 4

// idle and back-pressure counter width
// counters saturate at all ones
`define TCB_CNT_W 16

`endif

//--- verilog/tcb_bus_pkg.sv
`include "tcb_mon_settings.svh"

package tcb_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus field types
  ////////////////////////////////////////////////////////////////////////////

  // address
  typedef logic [`TCB_ABW-1:0] adr_t;
  // byte enable
  typedef logic [`TCB_BEW-1:0] ben_t;
  // read and write data
  typedef logic [`TCB_DBW-1:0] dat_t;

  ////////////////////////////////////////////////////////////////////////////
  // request record
  ////////////////////////////////////////////////////////////////////////////

  // everything sampled in the transfer cycle
  typedef struct packed {
    // optional request fields
    logic rpt;
    logic lck;
    // write enable
    // low means read
    logic wen;
    // address phase
    adr_t adr;
    ben_t ben;
    // write data, ignored on reads
    dat_t wdt;
  } tcb_req_t;

endpackage

//--- verilog/tcb_mon_pkg.sv
`include "tcb_mon_settings.svh"

package tcb_mon_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // counter types
  ////////////////////////////////////////////////////////////////////////////

  // idle and back-pressure counter
  typedef logic [`TCB_CNT_W-1:0] cnt_t;

  // saturation value
  localparam cnt_t CNT_MAX = '1;

  ////////////////////////////////////////////////////////////////////////////
  // timing record
  ////////////////////////////////////////////////////////////////////////////

  // cycles strictly between the previous transfer and this one
  typedef struct packed {
    // vld low cycles
    cnt_t idl;
    // vld high with rdy low
    cnt_t bpr;
  } tcb_tmg_t;

endpackage

//--- verilog/tcb_req_capture.sv
`timescale 1ns/10ps
`include "tcb_mon_settings.svh"

module tcb_req_capture (
  // clock and reset
  input  logic                  tcb,
  input  logic                  rst_n,
  // bus handshake
  input  logic                  vld,
  input  logic                  rdy,
  // bus request fields
  input  logic                  rpt,
  input  logic                  lck,
  input  logic                  wen,
  input  tcb_bus_pkg::adr_t     adr,
  input  tcb_bus_pkg::ben_t     ben,
  input  tcb_bus_pkg::dat_t     wdt,
  // buffer write side
  output logic                  push,
  output tcb_bus_pkg::tcb_req_t req_in,
  output tcb_mon_pkg::tcb_tmg_t tmg_in,
  // response cycle marker
  output logic                  rsp
);

  // transfer in this cycle
  logic                trn;
  // timing counters
  tcb_mon_pkg::cnt_t   cnt_idl;
  tcb_mon_pkg::cnt_t   cnt_bpr;
  // transfer history, bit i set means transfer i+1 cycles ago
  logic [`TCB_DLY-1:0] trn_dly;

  ////////////////////////////////////////////////////////////////////////////
  // transfer and record packing
  ////////////////////////////////////////////////////////////////////////////

  assign trn  = vld & rdy;
  // one record per transfer
  assign push = trn;

  // request fields as seen in the transfer cycle
  assign req_in = '{rpt: rpt, lck: lck, wen: wen, adr: adr, ben: ben, wdt: wdt};

  // counter values describe the gap before this transfer
  assign tmg_in = '{idl: cnt_idl, bpr: cnt_bpr};

  ////////////////////////////////////////////////////////////////////////////
  // idle and back-pressure counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      cnt_idl <= '0;
      cnt_bpr <= '0;
    end else if (trn) begin
      // restart for the next gap
      cnt_idl <= '0;
      cnt_bpr <= '0;
    end else if (!vld) begin
      // idle cycle, hold at max
      if (cnt_idl != tcb_mon_pkg::CNT_MAX) begin
        cnt_idl <= cnt_idl + 1'b1;
      end
    end else begin
      // vld without rdy
      if (cnt_bpr != tcb_mon_pkg::CNT_MAX) begin
        cnt_bpr <= cnt_bpr + 1'b1;
      end
    end
  end

  // response strobe
  // transfer delayed by TCB_DLY cycles
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      trn_dly <= '0;
    end else begin
      trn_dly[0] <= trn;
      for (int i = 1; i < `TCB_DLY; i++) begin
        trn_dly[i] <= trn_dly[i-1];
      end
    end
  end

  assign rsp = trn_dly[`TCB_DLY-1];

endmodule

//--- verilog/tcb_dly_fifo.sv
`timescale 1ns/10ps

module tcb_dly_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  // clock and reset
  input  logic     tcb,
  input  logic     rst_n,
  // write side
  input  logic     push,
  input  payload_t wdata,
  // read side
  input  logic     pop,
  output payload_t rdata,
  // occupancy flags
  output logic     full,
  output logic     empty
);

  // pointer and count widths
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // record storage
  payload_t   mem [DEPTH];
  // pointers wrap at DEPTH
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // entries held
  logic [CNT_W-1:0] cnt;

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // head entry without delay
  assign rdata = mem[rd_ptr];

  ////////////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  assign full  = (cnt == CNT_W'(DEPTH));
  assign empty = (cnt == '0);

endmodule

//--- verilog/tcb_rsp_pair.sv
`timescale 1ns/10ps

module tcb_rsp_pair (
  // clock and reset
  input  logic                  tcb,
  input  logic                  rst_n,
  // response cycle marker
  input  logic                  rsp,
  // buffer heads
  input  tcb_bus_pkg::tcb_req_t req_out,
  input  tcb_mon_pkg::tcb_tmg_t tmg_out,
  // bus response
  input  tcb_bus_pkg::dat_t     rdt,
  input  logic                  err,
  // buffer read side
  output logic                  pop,
  // log record
  output logic                  log_vld,
  output logic                  log_rpt,
  output logic                  log_lck,
  output logic                  log_wen,
  output tcb_bus_pkg::adr_t     log_adr,
  output tcb_bus_pkg::ben_t     log_ben,
  output tcb_bus_pkg::dat_t     log_dat,
  output logic                  log_err,
  output tcb_mon_pkg::cnt_t     log_idl,
  output tcb_mon_pkg::cnt_t     log_bpr
);

  // data shown in the log
  tcb_bus_pkg::dat_t dat;

  ////////////////////////////////////////////////////////////////////////////
  // pairing
  ////////////////////////////////////////////////////////////////////////////

  // both heads retire together in the response cycle
  assign pop = rsp;

  // write data from the queue, read data from the bus
  assign dat = req_out.wen ? req_out.wdt : rdt;

  ////////////////////////////////////////////////////////////////////////////
  // log registers
  ////////////////////////////////////////////////////////////////////////////

  // single-cycle strobe
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      log_vld <= 1'b0;
    end else begin
      log_vld <= rsp;
    end
  end

  // record fields
  // only meaningful while log_vld is high
  always_ff @(posedge tcb) begin
    if (rsp) begin
      log_rpt <= req_out.rpt;
      log_lck <= req_out.lck;
      log_wen <= req_out.wen;
      log_adr <= req_out.adr;
      log_ben <= req_out.ben;
      log_dat <= dat;
      // err belongs to the response cycle
      log_err <= err;
      log_idl <= tmg_out.idl;
      log_bpr <= tmg_out.bpr;
    end
  end

endmodule

//--- verilog/tcb_mon_top.sv
`timescale 1ns/10ps
`include "tcb_mon_settings.svh"

module tcb_mon_top (
  // clock and reset
  input  logic              tcb,
  input  logic              rst_n,
  // observed bus
  input  logic              vld,
  input  logic              rdy,
  input  logic              rpt,
  input  logic              lck,
  input  logic              wen,
  input  tcb_bus_pkg::adr_t adr,
  input  tcb_bus_pkg::ben_t ben,
  input  tcb_bus_pkg::dat_t wdt,
  input  tcb_bus_pkg::dat_t rdt,
  input  logic              err,
  // log record
  output logic              log_vld,
  output logic              log_rpt,
  output logic              log_lck,
  output logic              log_wen,
  output tcb_bus_pkg::adr_t log_adr,
  output tcb_bus_pkg::ben_t log_ben,
  output tcb_bus_pkg::dat_t log_dat,
  output logic              log_err,
  output tcb_mon_pkg::cnt_t log_idl,
  output tcb_mon_pkg::cnt_t log_bpr
);

  // buffer strobes
  logic                  push;
  logic                  pop;
  logic                  rsp;
  // records into and out of the buffers
  tcb_bus_pkg::tcb_req_t req_in;
  tcb_bus_pkg::tcb_req_t req_out;
  tcb_mon_pkg::tcb_tmg_t tmg_in;
  tcb_mon_pkg::tcb_tmg_t tmg_out;

  ////////////////////////////////////////////////////////////////////////////
  // producer
  ////////////////////////////////////////////////////////////////////////////

  tcb_req_capture u_capture (
    .tcb (tcb), .rst_n (rst_n),
    .vld (vld), .rdy (rdy),
    .rpt (rpt), .lck (lck), .wen (wen),
    .adr (adr), .ben (ben), .wdt (wdt),
    .push (push), .req_in (req_in), .tmg_in (tmg_in), .rsp (rsp)
  );

  // request records
  tcb_dly_fifo #(.payload_t (tcb_bus_pkg::tcb_req_t), .DEPTH (`TCB_MON_DEPTH)) u_req_fifo (
    .tcb (tcb), .rst_n (rst_n),
    .push (push), .wdata (req_in), .pop (pop), .rdata (req_out),
    .full (), .empty ()
  );

  // timing records
  // same strobes as the request buffer
  tcb_dly_fifo #(.payload_t (tcb_mon_pkg::tcb_tmg_t), .DEPTH (`TCB_MON_DEPTH)) u_tmg_fifo (
    .tcb (tcb), .rst_n (rst_n),
    .push (push), .wdata (tmg_in), .pop (pop), .rdata (tmg_out),
    .full (), .empty ()
  );

  ////////////////////////////////////////////////////////////////////////////
  // consumer
  ////////////////////////////////////////////////////////////////////////////

  tcb_rsp_pair u_pair (
    .tcb (tcb), .rst_n (rst_n),
    .rsp (rsp), .req_out (req_out), .tmg_out (tmg_out),
    .rdt (rdt), .err (err), .pop (pop),
    .log_vld (log_vld), .log_rpt (log_rpt), .log_lck (log_lck),
    .log_wen (log_wen), .log_adr (log_adr), .log_ben (log_ben),
    .log_dat (log_dat), .log_err (log_err),
    .log_idl (log_idl), .log_bpr (log_bpr)
  );

endmodule

//--- verif/tcb_mon_sva.sv
`timescale 1ns/10ps

module tcb_mon_sva #(
  parameter int W = 1
) (
  input logic         tcb,
  input logic         rst_n,
  input logic         push,
  input logic         pop,
  input logic         full,
  input logic         empty,
  input logic [W-1:0] rdata
);

  ////////////////////////////////////////////////////////////////////////////
  // buffer occupancy rules
  ////////////////////////////////////////////////////////////////////////////

  // a record pushed while full would overwrite the head
  a_no_push_full : assert property (@(posedge tcb) disable iff (!rst_n) !(push && full))
    else $error("delay buffer pushed while full");

  // a response with nothing queued
  a_no_pop_empty : assert property (@(posedge tcb) disable iff (!rst_n) !(pop && empty))
    else $error("delay buffer popped while empty");

  // head must hold a written record
  a_head_known : assert property (@(posedge tcb) disable iff (!rst_n)
    !empty |-> !$isunknown(rdata))
    else $error("delay buffer head holds unknown bits");

endmodule

// one checker per buffer instance
bind tcb_dly_fifo tcb_mon_sva #(.W ($bits(payload_t))) u_sva (
  .tcb (tcb), .rst_n (rst_n),
  .push (push), .pop (pop),
  .full (full), .empty (empty),
  .rdata (rdata)
);

//--- verif/tcb_mon_chk.sv
`timescale 1ns/10ps
`include "tcb_mon_settings.svh"

module tcb_mon_chk (
  input logic              tcb,
  input logic              rst_n,
  // log record from the DUT
  input logic              log_vld,
  input logic              log_rpt,
  input logic              log_lck,
  input logic              log_wen,
  input tcb_bus_pkg::adr_t log_adr,
  input tcb_bus_pkg::ben_t log_ben,
  input tcb_bus_pkg::dat_t log_dat,
  input logic              log_err,
  input tcb_mon_pkg::cnt_t log_idl,
  input tcb_mon_pkg::cnt_t log_bpr
);

  // one expected log record
  typedef struct packed {
    logic              rpt;
    logic              lck;
    logic              wen;
    tcb_bus_pkg::adr_t adr;
    tcb_bus_pkg::ben_t ben;
    tcb_bus_pkg::dat_t dat;
    logic              err;
    tcb_mon_pkg::cnt_t idl;
    tcb_mon_pkg::cnt_t bpr;
  } rec_t;

  // records still to come, oldest first
  rec_t exp_q[$];
  // edge on which each pending log is due
  int   due_q[$];
  // clock edges seen so far
  int   cyc      = 0;
  // mismatches in the running test
  int   test_err = 0;

  ////////////////////////////////////////////////////////////////////////////
  // queue handling from the testbench top
  ////////////////////////////////////////////////////////////////////////////

  task expect_rec(input logic rpt, input logic lck, input logic wen,
                  input tcb_bus_pkg::adr_t adr, input tcb_bus_pkg::ben_t ben,
                  input tcb_bus_pkg::dat_t dat, input logic err,
                  input tcb_mon_pkg::cnt_t idl, input tcb_mon_pkg::cnt_t bpr);
    exp_q.push_back('{rpt, lck, wen, adr, ben, dat, err, idl, bpr});
  endtask

  // transfer sampled on the next edge
  // its log strobe is seen TCB_DLY+1 edges after that
  task note_transfer();
    due_q.push_back(cyc + 1 + `TCB_DLY + 1);
  endtask

  // leftover records at the end of a test count as errors
  task settle_test(output int errs);
    if (exp_q.size() != 0) begin
      $display("test ended with %0d expected log records never seen", exp_q.size());
      test_err += exp_q.size();
      exp_q.delete();
    end
    if (due_q.size() != 0) begin
      $display("test ended with %0d transfers that produced no log record", due_q.size());
      test_err += due_q.size();
      due_q.delete();
    end
    errs     = test_err;
    test_err = 0;
  endtask

  // compare one field at the data width
  task cmp_field(input string name, input logic [`TCB_DBW-1:0] exp,
                 input logic [`TCB_DBW-1:0] act);
    if (exp !== act) begin
      $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
      test_err++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // log strobe compare
  ////////////////////////////////////////////////////////////////////////////

  // log outputs are registered and sampled on the edge
  always @(posedge tcb) begin : watch_log
    rec_t r;
    int   due;
    cyc++;
    if (rst_n && log_vld) begin
      if (due_q.size() == 0) begin
        $display("log record at %0t ns matches no transfer", $time);
        test_err++;
      end else begin
        due = due_q.pop_front();
        if (due != cyc) begin
          $display("Error at %0t ns: log_vld due on edge %0d came on edge %0d",
                   $time, due, cyc);
          test_err++;
        end
      end
      if (exp_q.size() == 0) begin
        $display("log record at %0t ns arrived with no record expected", $time);
        test_err++;
      end else begin
        r = exp_q.pop_front();
        cmp_field("log_rpt", 32'(r.rpt), 32'(log_rpt));
        cmp_field("log_lck", 32'(r.lck), 32'(log_lck));
        cmp_field("log_wen", 32'(r.wen), 32'(log_wen));
        cmp_field("log_adr", 32'(r.adr), 32'(log_adr));
        cmp_field("log_ben", 32'(r.ben), 32'(log_ben));
        cmp_field("log_dat", r.dat, log_dat);
        cmp_field("log_err", 32'(r.err), 32'(log_err));
        cmp_field("log_idl", 32'(r.idl), 32'(log_idl));
        cmp_field("log_bpr", 32'(r.bpr), 32'(log_bpr));
      end
    end
  end

endmodule

//--- verif/tcb_mon_tb.sv
`timescale 1ns/10ps
`include "tcb_mon_settings.svh"

module tcb_mon_tb;

  localparam int    CLK_NS = 8;
  // cycles until the last log of a test has been compared
  localparam int    DRAIN  = `TCB_DLY + 1;
  localparam string TRACE  = "verif/tcb_mon_trace.txt";

  // bus side
  logic              tcb;
  logic              rst_n;
  logic              vld, rdy, rpt, lck, wen, err;
  tcb_bus_pkg::adr_t adr;
  tcb_bus_pkg::ben_t ben;
  tcb_bus_pkg::dat_t wdt, rdt;
  // log side
  logic              log_vld, log_rpt, log_lck, log_wen, log_err;
  tcb_bus_pkg::adr_t log_adr;
  tcb_bus_pkg::ben_t log_ben;
  tcb_bus_pkg::dat_t log_dat;
  tcb_mon_pkg::cnt_t log_idl, log_bpr;

  // fields of the last trace line
  logic [31:0] fld [10];
  // bookkeeping
  int          limit_ns  = 0;
  int          pass_cnt  = 0;
  int          fail_cnt  = 0;
  int          bad_lines = 0;
  int          cur_num;
  string       cur_name;

  tcb_mon_top dut (
    .tcb (tcb), .rst_n (rst_n),
    .vld (vld), .rdy (rdy), .rpt (rpt), .lck (lck), .wen (wen),
    .adr (adr), .ben (ben), .wdt (wdt), .rdt (rdt), .err (err),
    .log_vld (log_vld), .log_rpt (log_rpt), .log_lck (log_lck),
    .log_wen (log_wen), .log_adr (log_adr), .log_ben (log_ben),
    .log_dat (log_dat), .log_err (log_err),
    .log_idl (log_idl), .log_bpr (log_bpr)
  );

  tcb_mon_chk u_chk (
    .tcb (tcb), .rst_n (rst_n),
    .log_vld (log_vld), .log_rpt (log_rpt), .log_lck (log_lck),
    .log_wen (log_wen), .log_adr (log_adr), .log_ben (log_ben),
    .log_dat (log_dat), .log_err (log_err),
    .log_idl (log_idl), .log_bpr (log_bpr)
  );

  initial begin
    tcb = 1'b0;
    forever #(CLK_NS / 2) tcb = ~tcb;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // apply one bus cycle
  // returns 1 ns after the edge that samples it
  task drive_cycle();
    vld = fld[0][0];
    rdy = fld[1][0];
    rpt = fld[2][0];
    lck = fld[3][0];
    wen = fld[4][0];
    adr = fld[5][`TCB_ABW-1:0];
    ben = fld[6][`TCB_BEW-1:0];
    wdt = fld[7];
    rdt = fld[8];
    err = fld[9][0];
    // a transfer starts the latency check
    if (fld[0][0] && fld[1][0]) begin
      u_chk.note_transfer();
    end
    @(posedge tcb);
    #1;
  endtask

  task drive_idle();
    for (int i = 0; i < 10; i++) begin
      fld[i] = '0;
    end
    drive_cycle();
  endtask

  // drain the pipe and ask the checker
  task end_test();
    int errs;
    repeat (DRAIN) drive_idle();
    u_chk.settle_test(errs);
    if (errs == 0) begin
      $display("test %0d %s: pass", cur_num, cur_name);
      pass_cnt++;
    end else begin
      $display("test %0d %s: fail with %0d errors", cur_num, cur_name, errs);
      fail_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("timeout: run exceeded %0d ns", limit_ns);
    $display("Regression failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // trace reader and main flow
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int          fd;
    int          n_s;
    int          open;
    string       line;
    logic [31:0] e [9];
    rst_n = 1'b0;
    {vld, rdy, rpt, lck, wen, err} = '0;
    adr = '0;
    ben = '0;
    wdt = '0;
    rdt = '0;
    n_s  = 0;
    open = 0;
    // first pass sizes the watchdog
    fd = $fopen(TRACE, "r");
    if (fd == 0) begin
      $display("cannot open trace file %s", TRACE);
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] == "S") n_s++;
      end
      $fclose(fd);
    end
    limit_ns = (n_s + `TCB_DLY + 20) * CLK_NS;
    // reset released in the first drive slot
    repeat (3) @(posedge tcb);
    #1;
    rst_n = 1'b1;
    fd = $fopen(TRACE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line[0] == "#") continue;
        if (line[0] == "T") begin
          if (open) end_test();
          if ($sscanf(line, "T %d %s", cur_num, cur_name) != 2) bad_lines++;
          open = 1;
        end else if (line[0] == "S") begin
          if ($sscanf(line, "S %h %h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                      fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9]) != 10) begin
            bad_lines++;
          end
          drive_cycle();
        end else if (line[0] == "E") begin
          if ($sscanf(line, "E %h %h %h %h %h %h %h %h %h", e[0], e[1], e[2], e[3],
                      e[4], e[5], e[6], e[7], e[8]) != 9) begin
            bad_lines++;
          end
          u_chk.expect_rec(e[0][0], e[1][0], e[2][0], e[3][`TCB_ABW-1:0],
                           e[4][`TCB_BEW-1:0], e[5], e[6][0],
                           e[7][`TCB_CNT_W-1:0], e[8][`TCB_CNT_W-1:0]);
        end else begin
          bad_lines++;
        end
      end
      $fclose(fd);
    end
    if (open) end_test();
    if (bad_lines != 0) $display("trace file held %0d lines that could not be read", bad_lines);
    $display("tests: %0d pass, %0d fail", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && bad_lines == 0 && pass_cnt > 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
verilog/tcb_bus_pkg.sv
verilog/tcb_mon_pkg.sv
verilog/tcb_req_capture.sv
verilog/tcb_dly_fifo.sv
verilog/tcb_rsp_pair.sv
verilog/tcb_mon_top.sv
verif/tcb_mon_sva.sv
verif/tcb_mon_chk.sv
verif/tcb_mon_tb.sv

//--- run.sh
#!/bin/sh
# build and run the monitor testbench with Verilator
# the result is taken from the simulation log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tcb_mon_tb -o tcb_mon_sim \
  && ./obj_dir/tcb_mon_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "Regression passed" sim.log && exit 0 || exit 1

//--- verif/tcb_mon_trace.txt
# T num name | S vld rdy rpt lck wen adr ben wdt rdt err | E rpt lck wen adr ben dat err idl bpr
# all hex; each test leaves 3 idle cycles of drain before the next one
T 1 write_after_idle
E 0 0 1 0010 f deadbeef 0 3 0
S 0 0 0 0 0 0000 0 00000000 00000000 0
S 0 0 0 0 0 0000 0 00000000 00000000 0
S 0 0 0 0 0 0000 0 00000000 00000000 0
S 1 1 0 0 1 0010 f deadbeef 00000000 0
S 0 0 0 0 0 0000 0 00000000 00000000 0
S 0 0 0 0 0 0000 0 00000000 00000000 0
T 2 reads_with_response
E 0 0 0 0020 f 12345678 0 5 0
E 0 0 0 0024 3 cafef00d 1 2 0
S 1 1 0 0 0 0020 f 00000000 00000000 0
S 0 0 0 0 0 0000 0 00000000 00000000 0
S 0 0 0 0 0 0000 0 00000000 12345678 0
S 1 1 0 0 0 0024 3 00000000 00000000 0
S 0 0 0 0 0 0000 0 00000000 00000000 0
S 0 0 0 0 0 0000 0 00000000 cafef00d 1
T 3 back_pressure
E 0 0 1 0030 f 11112222 0 6 3
S 0 0 0 0 0 0000 0 00000000 00000000 0
S 1 0 0 0 1 0030 f 11112222 00000000 0
S 1 0 0 0 1 0030 f 11112222 00000000 0
S 1 0 0 0 1 0030 f 11112222 00000000 0
S 1 1 0 0 1 0030 f 11112222 00000000 0
S 0 0 0 0 0 0000 0 00000000 00000000 0
S 0 0 0 0 0 0000 0 00000000 00000000 0
T 4 back_to_back
E 0 0 1 0040 f aaaa0001 0 5 0
E 0 0 0 0044 f bbbb0002 0 0 0
E 0 0 1 0048 f aaaa0003 0 0 0
E 0 0 0 004c f bbbb0004 0 0 0
S 1 1 0 0 1 0040 f aaaa0001 00000000 0
S 1 1 0 0 0 0044 f 00000000 00000000 0
S 1 1 0 0 1 0048 f aaaa0003 00000000 0
S 1 1 0 0 0 004c f 00000000 bbbb0002 0
S 0 0 0 0 0 0000 0 00000000 00000000 0
S 0 0 0 0 0 0000 0 00000000 bbbb0004 0
T 5 optional_fields
E 1 1 1 0050 5 01020304 0 5 0
E 0 1 0 0054 a 5a5a5a5a 0 0 0
E 1 0 1 0058 8 a5a5a5a5 1 0 0
S 1 1 1 1 1 0050 5 01020304 00000000 0
S 1 1 0 1 0 0054 a 00000000 00000000 0
S 1 1 1 0 1 0058 8 a5a5a5a5 00000000 0
S 0 0 0 0 0 0000 0 00000000 5a5a5a5a 0
S 0 0 0 0 0 0000 0 00000000 00000000 1
S 0 0 0 0 0 0000 0 00000000 00000000 0
